/* hdl/axi_cfg_pkg.sv */
`default_nettype none

// AXI channel widths and payload types shared by the remapper and its testbench
package axi_cfg_pkg;

  // Byte address width on both ports
  parameter int unsigned AddrWidth = 16;

  // Data bus width; one strobe bit covers one byte
  parameter int unsigned DataWidth = 32;
  parameter int unsigned StrbWidth = DataWidth / 8;

  // AXI4 burst length field, beats minus one
  parameter int unsigned LenWidth = 8;

  // Response code width on B and R
  parameter int unsigned RespWidth = 2;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;
  typedef logic [LenWidth-1:0]  len_t;
  typedef logic [RespWidth-1:0] resp_t;

endpackage

`default_nettype wire

/* hdl/remap_pkg.sv */
`default_nettype none

// Sizing defaults for the remap tables and the address channel state type
package remap_pkg;

  // Entries per table, which is also the number of distinct output IDs in use
  parameter int unsigned DefTableSize = 4;

  // Width of the IDs that the manager drives on the subordinate port
  parameter int unsigned DefSlvIdWidth = 4;

  // Width of the IDs towards the downstream subordinate
  // Has to be at least the table index width so every entry can be addressed
  parameter int unsigned DefMstIdWidth = 2;

  // Bursts that may be in flight under one output ID at the same time
  parameter int unsigned DefMaxTxnsPerId = 3;

  // Address channel state
  // Ready forwards new requests, Hold replays a stalled one with a fixed output ID
  typedef enum logic {
    Ready = 1'b0,
    Hold  = 1'b1
  } hold_e;

endpackage

`default_nettype wire

/* hdl/id_remap_table.sv */
`timescale 1ns/1ps
`default_nettype none

// Remap table for one direction
// Entry i belongs to output ID i and stores the input ID that owns it plus the
// number of bursts in flight under it; an entry with a zero count is free
module id_remap_table #(
  parameter int unsigned TableSize    = remap_pkg::DefTableSize,
  parameter int unsigned SlvIdWidth   = remap_pkg::DefSlvIdWidth,
  parameter int unsigned MaxTxnsPerId = remap_pkg::DefMaxTxnsPerId,
  localparam int unsigned IdxWidth    = ($clog2(TableSize) > 0) ? $clog2(TableSize) : 1
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  // Input ID of the request that waits on the address channel
  input  wire logic [SlvIdWidth-1:0] lookup_id_i,
  output logic                       exists_o,
  output logic      [IdxWidth-1:0]   exists_idx_o,
  output logic                       exists_full_o,
  output logic      [IdxWidth-1:0]   free_idx_o,
  output logic                       free_full_o,
  // Push takes its input ID from lookup_id_i
  input  wire logic                  push_i,
  input  wire logic [IdxWidth-1:0]   push_idx_i,
  // Pop on the final response of a burst
  input  wire logic                  pop_i,
  input  wire logic [IdxWidth-1:0]   pop_idx_i,
  output logic      [SlvIdWidth-1:0] pop_id_o
);

  // Counter must be able to hold MaxTxnsPerId itself
  localparam int unsigned CntWidth = $clog2(MaxTxnsPerId + 1);

  logic [SlvIdWidth-1:0] id_q  [TableSize];
  logic [CntWidth-1:0]   cnt_q [TableSize];
  logic [CntWidth-1:0]   cnt_d [TableSize];
  logic [IdxWidth-1:0]   exists_idx;

  // Lowest entry with a zero count
  // Scanning downwards lets the lowest hit overwrite any higher one
  always_comb begin
    free_idx_o  = '0;
    free_full_o = 1'b1;
    for (int i = TableSize - 1; i >= 0; i--) begin
      if (cnt_q[i] == '0) begin
        free_idx_o  = IdxWidth'(i);
        free_full_o = 1'b0;
      end
    end
  end

  // Lowest busy entry owned by the looked-up input ID
  // Only busy entries count, a free entry may still hold a stale input ID
  always_comb begin
    exists_idx = '0;
    exists_o   = 1'b0;
    for (int i = TableSize - 1; i >= 0; i--) begin
      if ((cnt_q[i] != '0) && (id_q[i] == lookup_id_i)) begin
        exists_idx = IdxWidth'(i);
        exists_o   = 1'b1;
      end
    end
  end

  assign exists_idx_o = exists_idx;

  // The ID has reached its burst limit and must wait for a release
  assign exists_full_o = (cnt_q[exists_idx] == CntWidth'(MaxTxnsPerId));

  // The response carries the output ID, the entry gives back the input ID
  assign pop_id_o = id_q[pop_idx_i];

  // Next counter values
  // A push and a pop in the same cycle are both applied, even to the same entry
  always_comb begin
    cnt_d = cnt_q;
    if (push_i) begin
      cnt_d[push_idx_i] = cnt_d[push_idx_i] + CntWidth'(1);
    end
    if (pop_i) begin
      cnt_d[pop_idx_i] = cnt_d[pop_idx_i] - CntWidth'(1);
    end
  end

  // Counters decide which entries are valid, so they start at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < TableSize; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Owner ID is written on every push
  // For a repeated ID the same value is written again
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      id_q[push_idx_i] <= lookup_id_i;
    end
  end

endmodule

`default_nettype wire

/* hdl/ax_remap_channel.sv */
`timescale 1ns/1ps
`default_nettype none

// Address channel control for AW or AR
// Picks the output ID for the waiting request, pushes it into the table and
// keeps the request stable while the downstream subordinate is not ready
module ax_remap_channel #(
  parameter int unsigned TableSize = remap_pkg::DefTableSize,
  localparam int unsigned IdxWidth = ($clog2(TableSize) > 0) ? $clog2(TableSize) : 1
) (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  // Handshake towards the manager
  input  wire logic                slv_valid_i,
  output logic                     slv_ready_o,
  // Handshake towards the subordinate
  output logic                     mst_valid_o,
  input  wire logic                mst_ready_i,
  output logic      [IdxWidth-1:0] mst_idx_o,
  // Table lookups for the waiting input ID
  input  wire logic                exists_i,
  input  wire logic [IdxWidth-1:0] exists_idx_i,
  input  wire logic                exists_full_i,
  input  wire logic [IdxWidth-1:0] free_idx_i,
  input  wire logic                free_full_i,
  // Table push
  output logic                     push_o,
  output logic      [IdxWidth-1:0] push_idx_o
);

  import remap_pkg::*;

  hold_e               state_q;
  hold_e               state_d;
  logic [IdxWidth-1:0] idx_q;
  logic [IdxWidth-1:0] pick_idx;
  logic                space_ok;
  logic                stall;

  // A known ID may go on while it is below its limit
  // A new ID needs a free entry
  assign space_ok = exists_i ? !exists_full_i : !free_full_i;

  // Reusing the owned index keeps responses of one input ID in order
  assign pick_idx   = exists_i ? exists_idx_i : free_idx_i;
  assign push_idx_o = pick_idx;

  // Request went out this cycle in Ready but the subordinate did not take it
  assign stall = (state_q == Ready) && mst_valid_o && !mst_ready_i;

  always_comb begin
    mst_valid_o = 1'b0;
    mst_idx_o   = pick_idx;
    slv_ready_o = 1'b0;
    push_o      = 1'b0;
    state_d     = state_q;
    case (state_q)
      Ready: begin
        // Forward in the same cycle and count the burst right away
        mst_valid_o = slv_valid_i && space_ok;
        push_o      = mst_valid_o;
        slv_ready_o = mst_valid_o && mst_ready_i;
        if (stall) begin
          state_d = Hold;
        end
      end
      Hold: begin
        // The burst is already counted, so there is no second push here
        // The table may change meanwhile, hence the registered index
        mst_valid_o = 1'b1;
        mst_idx_o   = idx_q;
        slv_ready_o = mst_ready_i;
        if (mst_ready_i) begin
          state_d = Ready;
        end
      end
      default: begin
        state_d = Ready;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Ready;
    end else begin
      state_q <= state_d;
    end
  end

  // Index of a stalled request, only read while in Hold
  always_ff @(posedge clk_i) begin
    if (stall) begin
      idx_q <= pick_idx;
    end
  end

endmodule

`default_nettype wire

/* hdl/axi_id_remap.sv */
`timescale 1ns/1ps
`default_nettype none

// AXI4 ID remapper
// Wide manager IDs are mapped onto a small set of output IDs, one table per
// direction; W, B and R go straight through with only the ID swapped back
module axi_id_remap #(
  parameter int unsigned TableSize    = remap_pkg::DefTableSize,
  parameter int unsigned SlvIdWidth   = remap_pkg::DefSlvIdWidth,
  parameter int unsigned MstIdWidth   = remap_pkg::DefMstIdWidth,
  parameter int unsigned MaxTxnsPerId = remap_pkg::DefMaxTxnsPerId
) (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  // Subordinate port, AW
  input  wire logic [SlvIdWidth-1:0]   slv_awid_i,
  input  wire axi_cfg_pkg::addr_t      slv_awaddr_i,
  input  wire axi_cfg_pkg::len_t       slv_awlen_i,
  input  wire logic                    slv_awvalid_i,
  output logic                         slv_awready_o,
  // Subordinate port, W
  input  wire axi_cfg_pkg::data_t      slv_wdata_i,
  input  wire axi_cfg_pkg::strb_t      slv_wstrb_i,
  input  wire logic                    slv_wlast_i,
  input  wire logic                    slv_wvalid_i,
  output logic                         slv_wready_o,
  // Subordinate port, B
  output logic      [SlvIdWidth-1:0]   slv_bid_o,
  output axi_cfg_pkg::resp_t           slv_bresp_o,
  output logic                         slv_bvalid_o,
  input  wire logic                    slv_bready_i,
  // Subordinate port, AR
  input  wire logic [SlvIdWidth-1:0]   slv_arid_i,
  input  wire axi_cfg_pkg::addr_t      slv_araddr_i,
  input  wire axi_cfg_pkg::len_t       slv_arlen_i,
  input  wire logic                    slv_arvalid_i,
  output logic                         slv_arready_o,
  // Subordinate port, R
  output logic      [SlvIdWidth-1:0]   slv_rid_o,
  output axi_cfg_pkg::data_t           slv_rdata_o,
  output axi_cfg_pkg::resp_t           slv_rresp_o,
  output logic                         slv_rlast_o,
  output logic                         slv_rvalid_o,
  input  wire logic                    slv_rready_i,
  // Manager port, AW
  output logic      [MstIdWidth-1:0]   mst_awid_o,
  output axi_cfg_pkg::addr_t           mst_awaddr_o,
  output axi_cfg_pkg::len_t            mst_awlen_o,
  output logic                         mst_awvalid_o,
  input  wire logic                    mst_awready_i,
  // Manager port, W
  output axi_cfg_pkg::data_t           mst_wdata_o,
  output axi_cfg_pkg::strb_t           mst_wstrb_o,
  output logic                         mst_wlast_o,
  output logic                         mst_wvalid_o,
  input  wire logic                    mst_wready_i,
  // Manager port, B
  input  wire logic [MstIdWidth-1:0]   mst_bid_i,
  input  wire axi_cfg_pkg::resp_t      mst_bresp_i,
  input  wire logic                    mst_bvalid_i,
  output logic                         mst_bready_o,
  // Manager port, AR
  output logic      [MstIdWidth-1:0]   mst_arid_o,
  output axi_cfg_pkg::addr_t           mst_araddr_o,
  output axi_cfg_pkg::len_t            mst_arlen_o,
  output logic                         mst_arvalid_o,
  input  wire logic                    mst_arready_i,
  // Manager port, R
  input  wire logic [MstIdWidth-1:0]   mst_rid_i,
  input  wire axi_cfg_pkg::data_t      mst_rdata_i,
  input  wire axi_cfg_pkg::resp_t      mst_rresp_i,
  input  wire logic                    mst_rlast_i,
  input  wire logic                    mst_rvalid_i,
  output logic                         mst_rready_o
);

  localparam int unsigned IdxWidth = ($clog2(TableSize) > 0) ? $clog2(TableSize) : 1;

  logic                wr_exists;
  logic [IdxWidth-1:0] wr_exists_idx;
  logic                wr_exists_full;
  logic [IdxWidth-1:0] wr_free_idx;
  logic                wr_free_full;
  logic                wr_push;
  logic [IdxWidth-1:0] wr_push_idx;
  logic                wr_pop;
  logic [IdxWidth-1:0] aw_idx;

  logic                rd_exists;
  logic [IdxWidth-1:0] rd_exists_idx;
  logic                rd_exists_full;
  logic [IdxWidth-1:0] rd_free_idx;
  logic                rd_free_full;
  logic                rd_push;
  logic [IdxWidth-1:0] rd_push_idx;
  logic                rd_pop;
  logic [IdxWidth-1:0] ar_idx;

  // Address payloads pass unchanged, only the ID is replaced
  assign mst_awaddr_o = slv_awaddr_i;
  assign mst_awlen_o  = slv_awlen_i;
  assign mst_araddr_o = slv_araddr_i;
  assign mst_arlen_o  = slv_arlen_i;

  // Table index becomes the output ID, upper bits are zero
  assign mst_awid_o = MstIdWidth'(aw_idx);
  assign mst_arid_o = MstIdWidth'(ar_idx);

  // W has no ID in AXI4 and goes straight through
  assign mst_wdata_o  = slv_wdata_i;
  assign mst_wstrb_o  = slv_wstrb_i;
  assign mst_wlast_o  = slv_wlast_i;
  assign mst_wvalid_o = slv_wvalid_i;
  assign slv_wready_o = mst_wready_i;

  // B closes one write burst
  assign slv_bresp_o  = mst_bresp_i;
  assign slv_bvalid_o = mst_bvalid_i;
  assign mst_bready_o = slv_bready_i;
  assign wr_pop       = mst_bvalid_i && slv_bready_i;

  // Only the last R beat closes a read burst
  assign slv_rdata_o  = mst_rdata_i;
  assign slv_rresp_o  = mst_rresp_i;
  assign slv_rlast_o  = mst_rlast_i;
  assign slv_rvalid_o = mst_rvalid_i;
  assign mst_rready_o = slv_rready_i;
  assign rd_pop       = mst_rvalid_i && slv_rready_i && mst_rlast_i;

  id_remap_table #(
    .TableSize    (TableSize),
    .SlvIdWidth   (SlvIdWidth),
    .MaxTxnsPerId (MaxTxnsPerId)
  ) u_wr_table (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lookup_id_i   (slv_awid_i),
    .exists_o      (wr_exists),
    .exists_idx_o  (wr_exists_idx),
    .exists_full_o (wr_exists_full),
    .free_idx_o    (wr_free_idx),
    .free_full_o   (wr_free_full),
    .push_i        (wr_push),
    .push_idx_i    (wr_push_idx),
    .pop_i         (wr_pop),
    .pop_idx_i     (mst_bid_i[IdxWidth-1:0]),
    .pop_id_o      (slv_bid_o)
  );

  id_remap_table #(
    .TableSize    (TableSize),
    .SlvIdWidth   (SlvIdWidth),
    .MaxTxnsPerId (MaxTxnsPerId)
  ) u_rd_table (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lookup_id_i   (slv_arid_i),
    .exists_o      (rd_exists),
    .exists_idx_o  (rd_exists_idx),
    .exists_full_o (rd_exists_full),
    .free_idx_o    (rd_free_idx),
    .free_full_o   (rd_free_full),
    .push_i        (rd_push),
    .push_idx_i    (rd_push_idx),
    .pop_i         (rd_pop),
    .pop_idx_i     (mst_rid_i[IdxWidth-1:0]),
    .pop_id_o      (slv_rid_o)
  );

  // Without atomics the two directions never share an output ID
  ax_remap_channel #(
    .TableSize (TableSize)
  ) u_aw_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .slv_valid_i   (slv_awvalid_i),
    .slv_ready_o   (slv_awready_o),
    .mst_valid_o   (mst_awvalid_o),
    .mst_ready_i   (mst_awready_i),
    .mst_idx_o     (aw_idx),
    .exists_i      (wr_exists),
    .exists_idx_i  (wr_exists_idx),
    .exists_full_i (wr_exists_full),
    .free_idx_i    (wr_free_idx),
    .free_full_i   (wr_free_full),
    .push_o        (wr_push),
    .push_idx_o    (wr_push_idx)
  );

  ax_remap_channel #(
    .TableSize (TableSize)
  ) u_ar_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .slv_valid_i   (slv_arvalid_i),
    .slv_ready_o   (slv_arready_o),
    .mst_valid_o   (mst_arvalid_o),
    .mst_ready_i   (mst_arready_i),
    .mst_idx_o     (ar_idx),
    .exists_i      (rd_exists),
    .exists_idx_i  (rd_exists_idx),
    .exists_full_i (rd_exists_full),
    .free_idx_i    (rd_free_idx),
    .free_full_i   (rd_free_full),
    .push_o        (rd_push),
    .push_idx_o    (rd_push_idx)
  );

endmodule

`default_nettype wire

/* sim/axi_id_remap_props.sv */
`timescale 1ns/1ps
`default_nettype none

// Handshake properties of the remapper address channels
// A stalled request must keep its valid, output ID and address until taken
module axi_id_remap_props #(
  parameter int unsigned MstIdWidth = remap_pkg::DefMstIdWidth
) (
  input wire logic                  clk_i,
  input wire logic                  rst_ni,
  input wire logic                  mst_awvalid_o,
  input wire logic                  mst_awready_i,
  input wire logic [MstIdWidth-1:0] mst_awid_o,
  input wire axi_cfg_pkg::addr_t    mst_awaddr_o,
  input wire logic                  mst_arvalid_o,
  input wire logic                  mst_arready_i,
  input wire logic [MstIdWidth-1:0] mst_arid_o,
  input wire axi_cfg_pkg::addr_t    mst_araddr_o
);

  // AW in hold keeps valid, ID and address
  aw_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mst_awvalid_o && !mst_awready_i) |=>
    (mst_awvalid_o && $stable(mst_awid_o) && $stable(mst_awaddr_o)))
    else $error("AW request changed while stalled");

  // AR in hold behaves the same
  ar_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mst_arvalid_o && !mst_arready_i) |=>
    (mst_arvalid_o && $stable(mst_arid_o) && $stable(mst_araddr_o)))
    else $error("AR request changed while stalled");

  // Nothing goes downstream while reset is held
  no_valid_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> (!mst_awvalid_o && !mst_arvalid_o))
    else $error("address valid raised during reset");

endmodule

bind axi_id_remap axi_id_remap_props #(
  .MstIdWidth (MstIdWidth)
) u_props (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .mst_awvalid_o (mst_awvalid_o),
  .mst_awready_i (mst_awready_i),
  .mst_awid_o    (mst_awid_o),
  .mst_awaddr_o  (mst_awaddr_o),
  .mst_arvalid_o (mst_arvalid_o),
  .mst_arready_i (mst_arready_i),
  .mst_arid_o    (mst_arid_o),
  .mst_araddr_o  (mst_araddr_o)
);

`default_nettype wire

/* sim/tb_axi_id_remap.sv */
`timescale 1ns/1ps
`default_nettype none

// Testbench for the AXI4 ID remapper
// A random manager drives the slv_ side, a random subordinate answers on the mst_ side,
// and a model of both remap tables predicts every output ID and returned input ID
module tb_axi_id_remap;

  import axi_cfg_pkg::*;
  import remap_pkg::*;

  localparam int SlvW    = DefSlvIdWidth;
  localparam int MstW    = DefMstIdWidth;
  localparam int NumIds  = DefTableSize;
  localparam int MaxTxns = DefMaxTxnsPerId;

  logic clk_i = 1'b0;
  logic rst_ni;

  logic [SlvW-1:0] slv_awid, slv_arid, slv_bid_o, slv_rid_o;
  addr_t slv_awaddr, slv_araddr, mst_awaddr_o, mst_araddr_o;
  len_t slv_awlen, slv_arlen, mst_awlen_o, mst_arlen_o;
  logic slv_awvalid, slv_awready_o, slv_arvalid, slv_arready_o;
  data_t slv_wdata, mst_wdata_o, slv_rdata_o, mst_rdata;
  strb_t slv_wstrb, mst_wstrb_o;
  logic slv_wlast, slv_wvalid, slv_wready_o, mst_wlast_o, mst_wvalid_o, mst_wready;
  resp_t slv_bresp_o, mst_bresp, slv_rresp_o, mst_rresp;
  logic slv_bvalid_o, slv_bready, mst_bvalid, mst_bready_o;
  logic slv_rlast_o, slv_rvalid_o, slv_rready, mst_rlast, mst_rvalid, mst_rready_o;
  logic [MstW-1:0] mst_awid_o, mst_arid_o, mst_bid, mst_rid;
  logic mst_awvalid_o, mst_awready, mst_arvalid_o, mst_arready;

  // Galois LFSR state that steps once per random bit
  logic [15:0] lfsr_q = 16'd50358;

  // Model tables where index 0 is the write direction and 1 the read direction
  int cnt [2][NumIds];
  logic [SlvW-1:0] own [2][NumIds];
  logic held [2];
  int held_idx [2];

  // Subordinate state with pending B per ID, queued read lengths per ID and the current R burst
  int b_pend [NumIds];
  int r_q [NumIds][$];
  logic r_busy;
  int r_left;
  logic [MstW-1:0] r_id;

  // Manager state of the running test
  int n_req, id_base, id_mask, gate_bits;
  int issued [2];
  int accepted [2];
  int id_stalls;
  int full_stalls;

  int errors = 0;
  int checks = 0;
  int tests = 0;
  int cycles = 0;
  int limit;

  always #20 clk_i = ~clk_i;

  // Watchdog on the total run length
  always @(posedge clk_i) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout: traffic did not drain within %0d cycles", limit);
      $display("Result: FAILED");
      $finish;
    end
  end

  axi_id_remap #(
    .TableSize    (DefTableSize),
    .SlvIdWidth   (DefSlvIdWidth),
    .MstIdWidth   (DefMstIdWidth),
    .MaxTxnsPerId (DefMaxTxnsPerId)
  ) uut (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .slv_awid_i (slv_awid), .slv_awaddr_i (slv_awaddr), .slv_awlen_i (slv_awlen),
    .slv_awvalid_i (slv_awvalid), .slv_awready_o (slv_awready_o),
    .slv_wdata_i (slv_wdata), .slv_wstrb_i (slv_wstrb), .slv_wlast_i (slv_wlast),
    .slv_wvalid_i (slv_wvalid), .slv_wready_o (slv_wready_o),
    .slv_bid_o (slv_bid_o), .slv_bresp_o (slv_bresp_o), .slv_bvalid_o (slv_bvalid_o),
    .slv_bready_i (slv_bready),
    .slv_arid_i (slv_arid), .slv_araddr_i (slv_araddr), .slv_arlen_i (slv_arlen),
    .slv_arvalid_i (slv_arvalid), .slv_arready_o (slv_arready_o),
    .slv_rid_o (slv_rid_o), .slv_rdata_o (slv_rdata_o), .slv_rresp_o (slv_rresp_o),
    .slv_rlast_o (slv_rlast_o), .slv_rvalid_o (slv_rvalid_o), .slv_rready_i (slv_rready),
    .mst_awid_o (mst_awid_o), .mst_awaddr_o (mst_awaddr_o), .mst_awlen_o (mst_awlen_o),
    .mst_awvalid_o (mst_awvalid_o), .mst_awready_i (mst_awready),
    .mst_wdata_o (mst_wdata_o), .mst_wstrb_o (mst_wstrb_o), .mst_wlast_o (mst_wlast_o),
    .mst_wvalid_o (mst_wvalid_o), .mst_wready_i (mst_wready),
    .mst_bid_i (mst_bid), .mst_bresp_i (mst_bresp), .mst_bvalid_i (mst_bvalid),
    .mst_bready_o (mst_bready_o),
    .mst_arid_o (mst_arid_o), .mst_araddr_o (mst_araddr_o), .mst_arlen_o (mst_arlen_o),
    .mst_arvalid_o (mst_arvalid_o), .mst_arready_i (mst_arready),
    .mst_rid_i (mst_rid), .mst_rdata_i (mst_rdata), .mst_rresp_i (mst_rresp),
    .mst_rlast_i (mst_rlast), .mst_rvalid_i (mst_rvalid), .mst_rready_o (mst_rready_o)
  );

  // Shift out n fresh LFSR bits with the newest bit lowest
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("error t=%0t %s: got %0h expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  // Output ID the remapper should give this input ID
  // A known ID at its burst limit gives -1 and a new ID with no free entry gives -2
  function automatic int expect_idx(input int dir, input logic [SlvW-1:0] id);
    for (int i = 0; i < NumIds; i++) begin
      if (cnt[dir][i] > 0 && own[dir][i] == id) begin
        return (cnt[dir][i] == MaxTxns) ? -1 : i;
      end
    end
    for (int i = 0; i < NumIds; i++) begin
      if (cnt[dir][i] == 0) begin
        return i;
      end
    end
    return -2;
  endfunction

  // Random output ID with a pending B (dir 0) or queued read burst (dir 1)
  function automatic int pick_response(input int dir);
    int start;
    int j;
    start = int'(rand_bits(2));
    for (int k = 0; k < NumIds; k++) begin
      j = (start + k) % NumIds;
      if ((dir == 0 && b_pend[j] > 0) || (dir == 1 && r_q[j].size() > 0)) begin
        return j;
      end
    end
    return -1;
  endfunction

  // Checks one address channel against the model and counts the pushed burst
  task automatic addr_step(input int dir, input string ch, input logic s_valid,
                           input logic s_ready, input logic m_valid, input logic m_ready,
                           input logic [SlvW-1:0] s_id, input logic [MstW-1:0] m_id,
                           input addr_t s_addr, input addr_t m_addr,
                           input len_t s_len, input len_t m_len);
    int exp;
    check_value({ch, " handshake pairing"}, 32'(s_valid && s_ready), 32'(m_valid && m_ready));
    if (s_valid && s_ready) begin
      accepted[dir]++;
    end
    if (held[dir]) begin
      check_value({"mst_", ch, "valid_o in hold"}, 32'(m_valid), 32'd1);
      check_value({"mst_", ch, "id_o in hold"}, 32'(m_id), held_idx[dir]);
      if (m_ready) begin
        held[dir] = 1'b0;
      end
    end else begin
      exp = s_valid ? expect_idx(dir, s_id) : -1;
      if (s_valid && exp == -1) begin
        id_stalls++;
      end
      if (s_valid && exp == -2) begin
        full_stalls++;
      end
      check_value({"mst_", ch, "valid_o"}, 32'(m_valid), 32'(s_valid && exp >= 0));
      if (m_valid && exp >= 0) begin
        check_value({"mst_", ch, "id_o"}, 32'(m_id), exp);
        cnt[dir][exp]++;
        own[dir][exp] = s_id;
        if (!m_ready) begin
          held[dir] = 1'b1;
          held_idx[dir] = exp;
        end
      end
    end
    if (m_valid) begin
      check_value({"mst_", ch, "addr_o"}, 32'(m_addr), 32'(s_addr));
      check_value({"mst_", ch, "len_o"}, 32'(m_len), 32'(s_len));
    end
  endtask

  // One clock cycle samples and checks, updates the models and drives the next inputs
  task automatic cycle_step();
    logic aw_hs, ar_hs, b_hs, r_hs, w_hs;
    int pick;
    @(posedge clk_i);
    aw_hs = mst_awvalid_o && mst_awready;
    ar_hs = mst_arvalid_o && mst_arready;
    b_hs  = mst_bvalid && slv_bready;
    r_hs  = mst_rvalid && slv_rready;
    w_hs  = slv_wvalid && mst_wready;
    // Pushes see the counters from before this edge, so they go first
    addr_step(0, "aw", slv_awvalid, slv_awready_o, mst_awvalid_o, mst_awready, slv_awid,
              mst_awid_o, slv_awaddr, mst_awaddr_o, slv_awlen, mst_awlen_o);
    addr_step(1, "ar", slv_arvalid, slv_arready_o, mst_arvalid_o, mst_arready, slv_arid,
              mst_arid_o, slv_araddr, mst_araddr_o, slv_arlen, mst_arlen_o);
    check_value("mst_wvalid_o", 32'(mst_wvalid_o), 32'(slv_wvalid));
    check_value("slv_wready_o", 32'(slv_wready_o), 32'(mst_wready));
    if (slv_wvalid) begin
      check_value("mst_wdata_o", mst_wdata_o, slv_wdata);
      check_value("mst_wstrb_o", 32'(mst_wstrb_o), 32'(slv_wstrb));
      check_value("mst_wlast_o", 32'(mst_wlast_o), 32'(slv_wlast));
    end
    check_value("slv_bvalid_o", 32'(slv_bvalid_o), 32'(mst_bvalid));
    check_value("mst_bready_o", 32'(mst_bready_o), 32'(slv_bready));
    if (mst_bvalid) begin
      check_value("slv_bid_o", 32'(slv_bid_o), 32'(own[0][mst_bid]));
      check_value("slv_bresp_o", 32'(slv_bresp_o), 32'(mst_bresp));
    end
    if (b_hs) begin
      cnt[0][mst_bid]--;
    end
    check_value("slv_rvalid_o", 32'(slv_rvalid_o), 32'(mst_rvalid));
    check_value("mst_rready_o", 32'(mst_rready_o), 32'(slv_rready));
    if (mst_rvalid) begin
      check_value("slv_rid_o", 32'(slv_rid_o), 32'(own[1][mst_rid]));
      check_value("slv_rdata_o", slv_rdata_o, mst_rdata);
      check_value("slv_rresp_o", 32'(slv_rresp_o), 32'(mst_rresp));
      check_value("slv_rlast_o", 32'(slv_rlast_o), 32'(mst_rlast));
    end
    if (r_hs && mst_rlast) begin
      cnt[1][mst_rid]--;
      r_busy = 1'b0;
    end
    // Subordinate remembers what it accepted
    if (aw_hs) begin
      b_pend[mst_awid_o]++;
    end
    if (ar_hs) begin
      r_q[mst_arid_o].push_back(int'(mst_arlen_o));
    end
    // Next B response is gated so responses can lag behind requests
    if (!mst_bvalid || b_hs) begin
      pick = (rand_bits(gate_bits) == 0) ? pick_response(0) : -1;
      mst_bvalid <= (pick >= 0);
      if (pick >= 0) begin
        b_pend[pick]--;
        mst_bid   <= MstW'(pick);
        mst_bresp <= resp_t'(rand_bits(2));
      end
    end
    // Next R beat where bursts of one ID leave in the order they came in
    if (!mst_rvalid || r_hs) begin
      if (!r_busy) begin
        pick = (rand_bits(gate_bits) == 0) ? pick_response(1) : -1;
        if (pick >= 0) begin
          r_busy = 1'b1;
          r_id   = MstW'(pick);
          r_left = r_q[pick].pop_front() + 1;
        end
      end
      if (r_busy && r_left > 0) begin
        r_left--;
        mst_rvalid <= 1'b1;
        mst_rid    <= r_id;
        mst_rdata  <= data_t'(rand_bits(32));
        mst_rresp  <= resp_t'(rand_bits(2));
        mst_rlast  <= (r_left == 0);
      end else begin
        mst_rvalid <= 1'b0;
      end
    end
    // Random ready on both sides
    mst_awready <= rand_bits(1) != 0;
    mst_arready <= rand_bits(1) != 0;
    mst_wready  <= rand_bits(1) != 0;
    slv_bready  <= rand_bits(2) != 0;
    slv_rready  <= rand_bits(2) != 0;
    // Manager issues a new request only once the previous one is taken
    if (!slv_awvalid || (slv_awvalid && slv_awready_o)) begin
      slv_awvalid <= 1'b0;
      if (issued[0] < n_req && rand_bits(1) != 0) begin
        issued[0]++;
        slv_awvalid <= 1'b1;
        slv_awid    <= SlvW'(id_base + (int'(rand_bits(4)) & id_mask));
        slv_awaddr  <= addr_t'(rand_bits(16));
        slv_awlen   <= len_t'(rand_bits(2));
      end
    end
    if (!slv_arvalid || (slv_arvalid && slv_arready_o)) begin
      slv_arvalid <= 1'b0;
      if (issued[1] < n_req && rand_bits(1) != 0) begin
        issued[1]++;
        slv_arvalid <= 1'b1;
        slv_arid    <= SlvW'(id_base + (int'(rand_bits(4)) & id_mask));
        slv_araddr  <= addr_t'(rand_bits(16));
        slv_arlen   <= len_t'(rand_bits(2));
      end
    end
    if (!slv_wvalid || w_hs) begin
      slv_wvalid <= rand_bits(1) != 0;
      slv_wdata  <= data_t'(rand_bits(32));
      slv_wstrb  <= strb_t'(rand_bits(4));
      slv_wlast  <= rand_bits(1) != 0;
    end
  endtask

  // All requests accepted and every burst released in the model
  function automatic logic drained();
    int sum;
    sum = 0;
    for (int i = 0; i < NumIds; i++) begin
      sum += cnt[0][i] + cnt[1][i];
    end
    return accepted[0] == n_req && accepted[1] == n_req && sum == 0;
  endfunction

  task automatic run_traffic(input string name, input int base, input int mask,
                             input int reqs, input int gate, input logic need_id_stall,
                             input logic need_full_stall);
    int err_before;
    err_before = errors;
    n_req = reqs;
    id_base = base;
    id_mask = mask;
    gate_bits = gate;
    issued = '{0, 0};
    accepted = '{0, 0};
    id_stalls = 0;
    full_stalls = 0;
    do begin
      cycle_step();
    end while (!drained());
    if (need_id_stall && id_stalls == 0) begin
      $display("%s: no request was ever held back by the per-ID burst limit", name);
      errors++;
    end
    if (need_full_stall && full_stalls == 0) begin
      $display("%s: no new ID was ever held back by a full table", name);
      errors++;
    end
    tests++;
    $display("test %s done: %0d errors", name, errors - err_before);
  endtask

  task automatic check_idle_outputs();
    check_value("mst_awvalid_o", 32'(mst_awvalid_o), 32'd0);
    check_value("mst_arvalid_o", 32'(mst_arvalid_o), 32'd0);
    check_value("slv_awready_o", 32'(slv_awready_o), 32'd0);
    check_value("slv_arready_o", 32'(slv_arready_o), 32'd0);
  endtask

  initial begin
    rst_ni <= 1'b0;
    slv_awvalid <= 1'b0;
    slv_awid <= '0;
    slv_awaddr <= '0;
    slv_awlen <= '0;
    slv_arvalid <= 1'b0;
    slv_arid <= '0;
    slv_araddr <= '0;
    slv_arlen <= '0;
    slv_wvalid <= 1'b0;
    slv_wdata <= '0;
    slv_wstrb <= '0;
    slv_wlast <= 1'b0;
    slv_bready <= 1'b0;
    slv_rready <= 1'b0;
    mst_awready <= 1'b0;
    mst_arready <= 1'b0;
    mst_wready <= 1'b0;
    mst_bvalid <= 1'b0;
    mst_bid <= '0;
    mst_bresp <= '0;
    mst_rvalid <= 1'b0;
    mst_rid <= '0;
    mst_rdata <= '0;
    mst_rresp <= '0;
    mst_rlast <= 1'b0;
    for (int i = 0; i < NumIds; i++) begin
      cnt[0][i] = 0;
      cnt[1][i] = 0;
      own[0][i] = '0;
      own[1][i] = '0;
      b_pend[i] = 0;
    end
    held = '{1'b0, 1'b0};
    held_idx = '{0, 0};
    r_busy = 1'b0;
    r_left = 0;
    r_id = '0;
    // Each request may cost one address beat and up to four data beats per direction
    limit = 20 * ((12 + 12 + 60) * 2 * 5);
    repeat (5) begin
      @(posedge clk_i);
      check_idle_outputs();
    end
    rst_ni <= 1'b1;
    repeat (2) begin
      @(posedge clk_i);
      check_idle_outputs();
    end
    tests++;
    $display("test reset done: %0d errors", errors);
    // One input ID with slow responses runs into the per-ID limit
    run_traffic("single_id", 5, 0, 12, 3, 1'b1, 1'b0);
    // Eight new IDs with slow responses fill the four table entries
    run_traffic("table_full", 8, 7, 12, 3, 1'b0, 1'b1);
    run_traffic("random_traffic", 0, 15, 60, 1, 1'b0, 1'b0);
    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
hdl/axi_cfg_pkg.sv
hdl/remap_pkg.sv
hdl/id_remap_table.sv
hdl/ax_remap_channel.sv
hdl/axi_id_remap.sv
sim/axi_id_remap_props.sv
sim/tb_axi_id_remap.sv

/* Makefile */
TOP := tb_axi_id_remap

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f \
		--Mdir obj_dir -o sim_$(TOP)

run: build
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "Result: PASSED" sim.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f list.f

clean:
	rm -rf obj_dir sim.log
